/* source/isa_pkg.sv */
package isa_pkg;

   localparam int word_w  = 16;
   localparam int shamt_w = $clog2(word_w);

   typedef logic [word_w-1:0] word_t;
   typedef logic [2:0]        reg_addr_t;
   typedef logic [4:0]        opcode_t;

   localparam reg_addr_t link_reg = 3'd7;   // JAL and JALR destination

   localparam opcode_t op_halt  = 5'b00000;
   localparam opcode_t op_nop   = 5'b00001;
   localparam opcode_t op_siic  = 5'b00010;
   localparam opcode_t op_rsvd  = 5'b00011;   // Runs as a nop in this core
   localparam opcode_t op_j     = 5'b00100;
   localparam opcode_t op_jr    = 5'b00101;
   localparam opcode_t op_jal   = 5'b00110;
   localparam opcode_t op_jalr  = 5'b00111;
   localparam opcode_t op_addi  = 5'b01000;
   localparam opcode_t op_subi  = 5'b01001;
   localparam opcode_t op_xori  = 5'b01010;
   localparam opcode_t op_andni = 5'b01011;
   localparam opcode_t op_beqz  = 5'b01100;
   localparam opcode_t op_bnez  = 5'b01101;
   localparam opcode_t op_bltz  = 5'b01110;
   localparam opcode_t op_bgez  = 5'b01111;
   localparam opcode_t op_st    = 5'b10000;
   localparam opcode_t op_ld    = 5'b10001;
   localparam opcode_t op_slbi  = 5'b10010;
   localparam opcode_t op_stu   = 5'b10011;
   localparam opcode_t op_roli  = 5'b10100;
   localparam opcode_t op_slli  = 5'b10101;
   localparam opcode_t op_rori  = 5'b10110;
   localparam opcode_t op_srli  = 5'b10111;
   localparam opcode_t op_lbi   = 5'b11000;
   localparam opcode_t op_btr   = 5'b11001;
   localparam opcode_t op_shift = 5'b11010;   // ROL SLL ROR SRL by funct
   localparam opcode_t op_arith = 5'b11011;   // ADD SUB XOR ANDN by funct
   localparam opcode_t op_seq   = 5'b11100;
   localparam opcode_t op_slt   = 5'b11101;
   localparam opcode_t op_sle   = 5'b11110;
   localparam opcode_t op_sco   = 5'b11111;

   typedef struct packed {
      opcode_t    opcode;
      reg_addr_t  rs;
      reg_addr_t  rd;
      logic [4:0] imm5;
   } i1_fmt_t;

   typedef struct packed {
      opcode_t    opcode;
      reg_addr_t  rs;
      logic [7:0] imm8;
   } i2_fmt_t;

   typedef struct packed {
      opcode_t    opcode;
      reg_addr_t  rs;
      reg_addr_t  rt;
      reg_addr_t  rd;
      logic [1:0] funct;
   } r_fmt_t;

   typedef struct packed {
      opcode_t     opcode;
      logic [10:0] disp11;
   } j_fmt_t;

   typedef union packed {
      i1_fmt_t i1;
      i2_fmt_t i2;
      r_fmt_t  r;
      j_fmt_t  j;
   } instr_t;

endpackage

/* source/ctrl_pkg.sv */
package ctrl_pkg;

   typedef enum logic [2:0] {
      alu_rol = 3'b000,
      alu_sll = 3'b001,
      alu_ror = 3'b010,
      alu_srl = 3'b011,
      alu_add = 3'b100,
      alu_and = 3'b101,
      alu_btr = 3'b110,
      alu_xor = 3'b111
   } alu_op_t;

   typedef enum logic [2:0] {
      ext_z5  = 3'b000,
      ext_s5  = 3'b001,
      ext_s8  = 3'b010,
      ext_s11 = 3'b011,
      ext_z8  = 3'b100
   } ext_op_t;

   typedef enum logic [2:0] {
      wb_alu  = 3'b000,
      wb_mem  = 3'b001,
      wb_link = 3'b010,
      wb_set  = 3'b011,
      wb_imm  = 3'b100,
      wb_slbi = 3'b101
   } wb_sel_t;

   typedef enum logic [1:0] {
      dst_r    = 2'b00,   // R format bits 4:2
      dst_i1   = 2'b01,   // I1 format bits 7:5
      dst_rs   = 2'b10,   // Bits 10:8
      dst_link = 2'b11
   } dst_sel_t;

   typedef enum logic [1:0] {
      set_co = 2'b00,
      set_eq = 2'b01,
      set_lt = 2'b10,
      set_le = 2'b11
   } set_sel_t;

   // Same order as the low opcode bits of BEQZ..BGEZ
   typedef enum logic [1:0] {
      br_eqz = 2'b00,
      br_nez = 2'b01,
      br_ltz = 2'b10,
      br_gez = 2'b11
   } br_sel_t;

endpackage

/* source/control.sv */
`timescale 1ns/100ps

module control import isa_pkg::*, ctrl_pkg::*; (
   input  instr_t   instr,
   output br_sel_t  br_sel,
   output set_sel_t set_sel,
   output logic     wr_en,
   output logic     mem_en,
   output logic     mem_wr_en,
   output wb_sel_t  wb_sel,
   output dst_sel_t dst_sel,
   output logic     oprnd_sel,
   output ext_op_t  ext_op,
   output alu_op_t  alu_op,
   output logic     inv_a,
   output logic     inv_b,
   output logic     carry_in,
   output logic     alu_signed,
   output logic     br_instr,
   output logic     jmp_instr,
   output logic     jmp_reg_instr,
   output logic     halt,
   output logic     err
);

   opcode_t    opcode;
   logic [1:0] funct;

   assign opcode = instr.r.opcode;
   assign funct  = instr.r.funct;

   always_comb begin
      br_sel        = br_eqz;
      set_sel       = set_co;
      wr_en         = 1'b0;
      mem_en        = 1'b0;
      mem_wr_en     = 1'b0;
      wb_sel        = wb_alu;
      dst_sel       = dst_r;
      oprnd_sel     = 1'b0;      // Operand B from rt
      ext_op        = ext_z5;
      alu_op        = alu_add;
      inv_a         = 1'b0;
      inv_b         = 1'b0;
      carry_in      = 1'b0;
      alu_signed    = 1'b1;
      br_instr      = 1'b0;
      jmp_instr     = 1'b0;
      jmp_reg_instr = 1'b0;
      halt          = 1'b0;
      err           = 1'b0;

      case (opcode)
         op_halt: halt = 1'b1;
         op_nop, op_siic, op_rsvd: begin
            // Only the PC advances
         end
         op_addi, op_subi: begin
            wr_en     = 1'b1;
            dst_sel   = dst_i1;
            oprnd_sel = 1'b1;
            ext_op    = ext_s5;
            inv_a     = (opcode == op_subi);   // SUBI is imm minus rs
            carry_in  = (opcode == op_subi);
         end
         op_xori, op_andni: begin
            wr_en     = 1'b1;
            dst_sel   = dst_i1;
            oprnd_sel = 1'b1;
            alu_op    = (opcode == op_xori) ? alu_xor : alu_and;
            inv_b     = (opcode == op_andni);
         end
         op_roli, op_slli, op_rori, op_srli: begin
            wr_en     = 1'b1;
            dst_sel   = dst_i1;
            oprnd_sel = 1'b1;
            alu_op    = alu_op_t'({1'b0, opcode[1:0]});
         end
         op_st, op_ld, op_stu: begin
            mem_en    = 1'b1;
            mem_wr_en = (opcode != op_ld);
            wr_en     = (opcode != op_st);
            wb_sel    = (opcode == op_ld) ? wb_mem : wb_alu;
            dst_sel   = (opcode == op_stu) ? dst_rs : dst_i1;   // STU writes back the address
            oprnd_sel = 1'b1;
            ext_op    = ext_s5;
         end
         op_lbi, op_slbi: begin
            wr_en   = 1'b1;
            dst_sel = dst_rs;
            wb_sel  = (opcode == op_lbi) ? wb_imm : wb_slbi;
            ext_op  = (opcode == op_lbi) ? ext_s8 : ext_z8;
         end
         op_btr: begin
            err    = (funct != 2'b00);   // Funct bits must be clear
            wr_en  = (funct == 2'b00);
            alu_op = alu_btr;
         end
         op_arith: begin
            wr_en = 1'b1;
            case (funct)
               2'b00: alu_op = alu_add;
               2'b01: begin   // SUB is rt minus rs
                  inv_a    = 1'b1;
                  carry_in = 1'b1;
               end
               2'b10: alu_op = alu_xor;
               default: begin   // ANDN
                  alu_op = alu_and;
                  inv_b  = 1'b1;
               end
            endcase
         end
         op_shift: begin
            wr_en  = 1'b1;
            alu_op = alu_op_t'({1'b0, funct});
         end
         op_seq, op_slt, op_sle, op_sco: begin
            err    = (funct != 2'b00);
            wr_en  = (funct == 2'b00);
            wb_sel = wb_set;
            case (opcode)
               op_seq:  set_sel = set_eq;
               op_slt:  set_sel = set_lt;
               op_sle:  set_sel = set_le;
               default: begin
                  set_sel    = set_co;
                  alu_signed = 1'b0;   // Carry is an unsigned result
               end
            endcase
         end
         op_beqz, op_bnez, op_bltz, op_bgez: begin
            br_instr = 1'b1;
            br_sel   = br_sel_t'(opcode[1:0]);
            ext_op   = ext_s8;
         end
         op_j, op_jal, op_jr, op_jalr: begin
            jmp_instr     = 1'b1;
            jmp_reg_instr = opcode[0];   // JR and JALR
            ext_op        = opcode[0] ? ext_s8 : ext_s11;
            wr_en         = opcode[1];   // Link forms
            wb_sel        = wb_link;
            dst_sel       = dst_link;
         end
         default: err = 1'b1;
      endcase
   end

endmodule

/* source/alu.sv */
`timescale 1ns/100ps

module alu import isa_pkg::*, ctrl_pkg::*; (
   input  word_t    a,
   input  word_t    b,
   input  alu_op_t  op,
   input  logic     inv_a,
   input  logic     inv_b,
   input  logic     carry_in,
   input  logic     alu_signed,
   input  set_sel_t set_sel,
   output word_t    result,
   output logic     set_bit
);

   word_t               a_in;
   word_t               b_in;
   word_t               sum;
   word_t               rev;
   logic                carry_out;
   logic                eq;
   logic                lt;
   logic [shamt_w-1:0]  shamt;
   logic [2*word_w-1:0] rot_l;
   logic [2*word_w-1:0] rot_r;

   assign a_in  = inv_a ? ~a : a;
   assign b_in  = inv_b ? ~b : b;
   assign shamt = b[shamt_w-1:0];

   assign {carry_out, sum} = a_in + b_in + carry_in;

   assign rot_l = {a_in, a_in} << shamt;   // Upper half holds the rotate
   assign rot_r = {a_in, a_in} >> shamt;

   always_comb begin
      for (int i = 0; i < word_w; i++) begin
         rev[i] = a[word_w-1-i];
      end
   end

   always_comb begin
      case (op)
         alu_rol: result = rot_l[2*word_w-1 -: word_w];
         alu_sll: result = a_in << shamt;
         alu_ror: result = rot_r[word_w-1:0];
         alu_srl: result = a_in >> shamt;
         alu_add: result = sum;
         alu_and: result = a_in & b_in;
         alu_btr: result = rev;
         default: result = a_in ^ b_in;
      endcase
   end

   // Compares use the raw rs and rt values
   assign eq = (a == b);
   assign lt = alu_signed ? ($signed(a) < $signed(b)) : (a < b);

   always_comb begin
      case (set_sel)
         set_eq:  set_bit = eq;
         set_lt:  set_bit = lt;
         set_le:  set_bit = lt | eq;
         default: set_bit = carry_out;
      endcase
   end

endmodule

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file import isa_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  reg_addr_t rs_addr,
   input  reg_addr_t rt_addr,
   input  reg_addr_t wr_addr,
   input  word_t     wr_data,
   input  logic      wr_en,
   output word_t     rs_data,
   output word_t     rt_data
);

   localparam int num_regs = 2 ** $bits(reg_addr_t);

   word_t regs [num_regs];

   always_ff @(posedge clk) begin
      if (rst) begin
         regs <= '{default: '0};
      end else if (wr_en) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // No bypass so a write shows up on the next cycle
   assign rs_data = regs[rs_addr];
   assign rt_data = regs[rt_addr];

endmodule

/* source/pc_unit.sv */
`timescale 1ns/100ps

module pc_unit import isa_pkg::*, ctrl_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    halt,
   input  logic    err,
   input  logic    br_instr,
   input  logic    jmp_instr,
   input  logic    jmp_reg_instr,
   input  br_sel_t br_sel,
   input  word_t   rs_data,
   input  word_t   imm,
   output word_t   pc,
   output word_t   pc_next_seq,
   output logic    halted
);

   logic  taken;
   word_t pc_next;

   assign pc_next_seq = pc + word_t'(2);   // Also the link value

   always_comb begin
      case (br_sel)
         br_eqz:  taken = (rs_data == '0);
         br_nez:  taken = (rs_data != '0);
         br_ltz:  taken = rs_data[word_w-1];
         default: taken = ~rs_data[word_w-1];
      endcase
   end

   always_comb begin
      if (jmp_instr && jmp_reg_instr)
         pc_next = rs_data + imm;   // JR and JALR
      else if (jmp_instr || (br_instr && taken))
         pc_next = pc_next_seq + imm;
      else
         pc_next = pc_next_seq;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc     <= '0;
         halted <= 1'b0;
      end else begin
         if (halt)
            halted <= 1'b1;   // Sticky until reset
         if (!(halt || halted || err))
            pc <= pc_next;
      end
   end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top import isa_pkg::*, ctrl_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  word_t instr,
   input  word_t mem_rdata,
   output word_t instr_addr,
   output word_t mem_addr,
   output word_t mem_wdata,
   output logic  mem_en,
   output logic  mem_wr_en,
   output logic  halted,
   output logic  err
);

   instr_t    ir;
   br_sel_t   br_sel;
   set_sel_t  set_sel;
   wb_sel_t   wb_sel;
   dst_sel_t  dst_sel;
   ext_op_t   ext_op;
   alu_op_t   alu_op;
   logic      ctl_wr_en;
   logic      ctl_mem_en;
   logic      ctl_mem_wr_en;
   logic      oprnd_sel;
   logic      inv_a;
   logic      inv_b;
   logic      carry_in;
   logic      alu_signed;
   logic      br_instr;
   logic      jmp_instr;
   logic      jmp_reg_instr;
   logic      halt;
   logic      set_bit;
   reg_addr_t wr_addr;
   word_t     wr_data;
   word_t     rs_data;
   word_t     rt_data;
   word_t     ext_imm;
   word_t     alu_b;
   word_t     alu_result;
   word_t     pc_next_seq;

   assign ir = instr;

   control u_control (
      .instr(ir), .br_sel, .set_sel, .wr_en(ctl_wr_en), .mem_en(ctl_mem_en),
      .mem_wr_en(ctl_mem_wr_en), .wb_sel, .dst_sel, .oprnd_sel, .ext_op, .alu_op,
      .inv_a, .inv_b, .carry_in, .alu_signed, .br_instr, .jmp_instr,
      .jmp_reg_instr, .halt, .err
   );

   always_comb begin
      case (ext_op)
         ext_z5:  ext_imm = word_t'(ir.i1.imm5);
         ext_s5:  ext_imm = {{(word_w-5){ir.i1.imm5[4]}}, ir.i1.imm5};
         ext_s8:  ext_imm = {{(word_w-8){ir.i2.imm8[7]}}, ir.i2.imm8};
         ext_s11: ext_imm = {{(word_w-11){ir.j.disp11[10]}}, ir.j.disp11};
         default: ext_imm = word_t'(ir.i2.imm8);   // Zero-extended byte for SLBI
      endcase
   end

   always_comb begin
      case (dst_sel)
         dst_r:   wr_addr = ir.r.rd;
         dst_i1:  wr_addr = ir.i1.rd;
         dst_rs:  wr_addr = ir.i2.rs;
         default: wr_addr = link_reg;
      endcase
   end

   always_comb begin
      case (wb_sel)
         wb_mem:  wr_data = mem_rdata;
         wb_link: wr_data = pc_next_seq;
         wb_set:  wr_data = word_t'(set_bit);
         wb_imm:  wr_data = ext_imm;
         wb_slbi: wr_data = {rs_data[word_w-9:0], ext_imm[7:0]};
         default: wr_data = alu_result;
      endcase
   end

   assign alu_b = oprnd_sel ? ext_imm : rt_data;

   // rt_addr carries the rd field of ST and STU
   reg_file u_reg_file (
      .clk, .rst, .rs_addr(ir.r.rs), .rt_addr(ir.r.rt), .wr_addr, .wr_data,
      .wr_en(ctl_wr_en & ~halted), .rs_data, .rt_data
   );

   alu u_alu (
      .a(rs_data), .b(alu_b), .op(alu_op), .inv_a, .inv_b, .carry_in, .alu_signed,
      .set_sel, .result(alu_result), .set_bit
   );

   pc_unit u_pc_unit (
      .clk, .rst, .halt, .err, .br_instr, .jmp_instr, .jmp_reg_instr, .br_sel,
      .rs_data, .imm(ext_imm), .pc(instr_addr), .pc_next_seq, .halted
   );

   assign mem_addr  = alu_result;
   assign mem_wdata = rt_data;
   assign mem_en    = ctl_mem_en & ~halted;
   assign mem_wr_en = ctl_mem_wr_en & ~halted;

endmodule

/* test/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;   // Power-on reset for 4 cycles
   end

   always #5 clk = ~clk;   // 10 ns period

endmodule

/* test/cpu_props.sv */
`timescale 1ns/100ps

module cpu_props import isa_pkg::*; (
   input logic  clk,
   input logic  rst,
   input word_t instr_addr,
   input logic  mem_en,
   input logic  mem_wr_en,
   input logic  halted,
   input logic  err
);

   wr_needs_en: assert property (@(posedge clk) disable iff (rst)
      mem_wr_en |-> mem_en)
      else $error("mem_wr_en without mem_en");

   halt_no_write: assert property (@(posedge clk) disable iff (rst)
      halted |-> !mem_wr_en)
      else $error("memory write while halted");

   halt_pc_frozen: assert property (@(posedge clk) disable iff (rst)
      halted |=> $stable(instr_addr))
      else $error("instr_addr moved while halted");

   err_no_write: assert property (@(posedge clk) disable iff (rst)
      err |-> !mem_wr_en)
      else $error("memory write on an undefined opcode");

endmodule

bind cpu_top cpu_props u_props (
   .clk(clk),
   .rst(rst),
   .instr_addr(instr_addr),
   .mem_en(mem_en),
   .mem_wr_en(mem_wr_en),
   .halted(halted),
   .err(err)
);

/* test/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb import isa_pkg::*; ();

   logic   clk;
   logic   por_rst;
   logic   tb_rst;
   logic   rst;
   word_t  instr;
   word_t  mem_rdata;
   word_t  instr_addr;
   word_t  mem_addr;
   word_t  mem_wdata;
   logic   mem_en;
   logic   mem_wr_en;
   logic   halted;
   logic   err;
   word_t  imem [0:127];
   word_t  dmem [0:255];
   word_t  st_addr [$];
   word_t  st_data [$];
   word_t  exp_addr [$];
   word_t  exp_data [$];
   int     prog_len;
   integer seed;

   clk_gen u_clk_gen (.clk(clk), .rst(por_rst));

   assign rst = por_rst | tb_rst;

   cpu_top uut (
      .clk, .rst, .instr, .mem_rdata, .instr_addr, .mem_addr, .mem_wdata,
      .mem_en, .mem_wr_en, .halted, .err
   );

   // Combinational read ports and writes at the edge
   assign instr     = imem[instr_addr[7:1]];
   assign mem_rdata = mem_en ? dmem[mem_addr[8:1]] : 'x;   // Data only while enabled

   always @(posedge clk) begin
      if (!rst && mem_wr_en) begin
         dmem[mem_addr[8:1]] <= mem_wdata;
         st_addr.push_back(mem_addr);
         st_data.push_back(mem_wdata);
      end
   end

   function automatic word_t fill_word(word_t addr);
      return (addr * 16'h0307) ^ 16'ha5c3;
   endfunction

   function automatic word_t enc_i1(opcode_t op, reg_addr_t rs, reg_addr_t rd, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic word_t enc_i2(opcode_t op, reg_addr_t rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic word_t enc_r(opcode_t op, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                   logic [1:0] funct);
      return {op, rs, rt, rd, funct};
   endfunction

   function automatic word_t enc_j(opcode_t op, logic [10:0] disp);
      return {op, disp};
   endfunction

   function automatic word_t sext5(logic [4:0] v);
      return {{11{v[4]}}, v};
   endfunction

   function automatic word_t shift_ref(int kind, word_t v, logic [3:0] s);
      word_t l;
      word_t r;
      l = v << s;
      r = v >> s;
      case (kind)
         0: return (s == 4'd0) ? v : (l | (v >> (16 - s)));   // Rotate left
         1: return l;
         2: return (s == 4'd0) ? v : (r | (v << (16 - s)));
         default: return r;
      endcase
   endfunction

   function automatic word_t bit_reverse(word_t v);
      word_t r;
      for (int i = 0; i < 16; i++) r[i] = v[15-i];
      return r;
   endfunction

   function automatic word_t set_ref(int kind, word_t a, word_t b);
      logic [16:0] sum;
      sum = {1'b0, a} + {1'b0, b};
      case (kind)
         0: return word_t'(a == b);
         1: return word_t'($signed(a) < $signed(b));
         2: return word_t'($signed(a) <= $signed(b));
         default: return word_t'(sum[16]);   // Carry out
      endcase
   endfunction

   function automatic logic branch_ref(opcode_t op, word_t v);
      case (op)
         op_beqz: return v == 16'h0000;
         op_bnez: return v != 16'h0000;
         op_bltz: return v[15];
         default: return !v[15];
      endcase
   endfunction

   function automatic word_t next_pc();
      return word_t'(prog_len * 2);
   endfunction

   task automatic fail_now(string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_word(string name, word_t got, word_t exp);
      if (got !== exp)
         fail_now($sformatf("Error: %s is %h, expected %h", name, got, exp));
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp)
         fail_now($sformatf("Error: %s is %h, expected %h", name, got, exp));
   endtask

   task automatic emit(word_t w);
      imem[prog_len] = w;
      prog_len++;
   endtask

   task automatic begin_program();
      prog_len = 0;
      exp_addr.delete();
      exp_data.delete();
      for (int i = 0; i < 128; i++) imem[i] = 16'h0000;   // HALT everywhere
   endtask

   task automatic load_const(reg_addr_t r, word_t v);
      emit(enc_i2(op_lbi, r, v[15:8]));
      emit(enc_i2(op_slbi, r, v[7:0]));
   endtask

   task automatic store_expect(reg_addr_t r, word_t v);
      emit(enc_i1(op_st, 3'd0, r, 5'd0));
      exp_addr.push_back(16'h0000);
      exp_data.push_back(v);
   endtask

   task automatic marker(logic [7:0] id, logic expected);
      emit(enc_i2(op_lbi, 3'd6, id));
      emit(enc_i1(op_st, 3'd0, 3'd6, 5'd0));
      if (expected) begin
         exp_addr.push_back(16'h0000);
         exp_data.push_back({8'h00, id});
      end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      tb_rst = 1'b1;
      st_addr.delete();
      st_data.delete();
      repeat (4) @(negedge clk);
      tb_rst = 1'b0;
   endtask

   task automatic wait_halted();
      int cycles;
      cycles = 0;
      while (!halted && cycles < 400) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) fail_now("Timeout: the core never reached HALT");
   endtask

   task automatic run_program();
      apply_reset();
      wait_halted();
      check_word("store_count", word_t'(st_data.size()), word_t'(exp_data.size()));
      foreach (exp_data[i]) begin
         check_word("mem_addr", st_addr[i], exp_addr[i]);
         check_word("mem_wdata", st_data[i], exp_data[i]);
      end
   endtask

   task automatic test_arith();
      word_t      a;
      word_t      b;
      logic [4:0] i;
      a = word_t'($random(seed));
      b = word_t'($random(seed));
      i = 5'($random(seed));
      begin_program();
      load_const(3'd1, a);
      load_const(3'd2, b);
      emit(enc_i1(op_addi, 3'd1, 3'd3, i));
      store_expect(3'd3, a + sext5(i));
      emit(enc_i1(op_subi, 3'd1, 3'd3, i));
      store_expect(3'd3, sext5(i) - a);
      emit(enc_i1(op_xori, 3'd1, 3'd3, i));
      store_expect(3'd3, a ^ word_t'(i));
      emit(enc_i1(op_andni, 3'd1, 3'd3, i));
      store_expect(3'd3, a & ~word_t'(i));
      emit(enc_r(op_arith, 3'd1, 3'd2, 3'd3, 2'd0));
      store_expect(3'd3, a + b);
      emit(enc_r(op_arith, 3'd1, 3'd2, 3'd3, 2'd1));
      store_expect(3'd3, b - a);   // rt minus rs
      emit(enc_r(op_arith, 3'd1, 3'd2, 3'd3, 2'd2));
      store_expect(3'd3, a ^ b);
      emit(enc_r(op_arith, 3'd1, 3'd2, 3'd3, 2'd3));
      store_expect(3'd3, a & ~b);
      run_program();
   endtask

   task automatic test_shift();
      word_t      a;
      word_t      b;
      logic [4:0] i;
      a = word_t'($random(seed));
      b = word_t'($random(seed));
      i = 5'($random(seed));
      begin_program();
      load_const(3'd1, a);
      load_const(3'd2, b);
      for (int k = 0; k < 4; k++) begin
         emit(enc_i1(opcode_t'(op_roli + k), 3'd1, 3'd3, i));
         store_expect(3'd3, shift_ref(k, a, i[3:0]));
         emit(enc_r(op_shift, 3'd1, 3'd2, 3'd3, 2'(k)));
         store_expect(3'd3, shift_ref(k, a, b[3:0]));
      end
      emit(enc_r(op_btr, 3'd1, 3'd0, 3'd3, 2'd0));
      store_expect(3'd3, bit_reverse(a));
      run_program();
   endtask

   task automatic test_memory();
      word_t c;
      c = word_t'($random(seed));
      begin_program();
      load_const(3'd1, 16'h0040);
      load_const(3'd2, c);
      emit(enc_i1(op_ld, 3'd1, 3'd3, 5'd4));
      store_expect(3'd3, fill_word(16'h0044));
      emit(enc_i1(op_st, 3'd1, 3'd2, 5'b11110));   // Offset of -2
      exp_addr.push_back(16'h003e);
      exp_data.push_back(c);
      emit(enc_i1(op_stu, 3'd1, 3'd2, 5'd6));
      exp_addr.push_back(16'h0046);
      exp_data.push_back(c);
      store_expect(3'd1, 16'h0046);
      emit(enc_i2(op_lbi, 3'd4, 8'h85));
      store_expect(3'd4, 16'hff85);
      emit(enc_i2(op_slbi, 3'd4, 8'h3c));
      store_expect(3'd4, 16'h853c);
      run_program();
   endtask

   task automatic test_set();
      word_t pa [5] = '{16'h0005, 16'h7fff, 16'h8000, 16'hffff, 16'h0003};
      word_t pb [5] = '{16'h0005, 16'h8000, 16'h7fff, 16'h0001, 16'h0004};
      begin_program();
      for (int p = 0; p < 5; p++) begin
         load_const(3'd1, pa[p]);
         load_const(3'd2, pb[p]);
         for (int k = 0; k < 4; k++) begin
            emit(enc_r(opcode_t'(op_seq + k), 3'd1, 3'd2, 3'd3, 2'd0));
            store_expect(3'd3, set_ref(k, pa[p], pb[p]));
         end
      end
      run_program();
   endtask

   task automatic test_flow();
      opcode_t   ops [8] = '{op_beqz, op_beqz, op_bnez, op_bnez,
                             op_bltz, op_bltz, op_bgez, op_bgez};
      reg_addr_t regs [8] = '{3'd1, 3'd2, 3'd2, 3'd1, 3'd3, 3'd2, 3'd1, 3'd3};
      word_t     vals [4] = '{16'h0000, 16'h0000, 16'h0005, 16'h8000};
      logic [7:0] id;
      word_t     here;
      id = 8'd1;
      begin_program();
      load_const(3'd1, vals[1]);
      load_const(3'd2, vals[2]);
      load_const(3'd3, vals[3]);
      for (int n = 0; n < 8; n++) begin
         emit(enc_i2(ops[n], regs[n], 8'd4));   // Skips one marker
         marker(id, !branch_ref(ops[n], vals[regs[n]]));
         marker(id + 8'd1, 1'b1);
         id = id + 8'd2;
      end
      emit(enc_j(op_j, 11'd4));
      marker(id, 1'b0);
      marker(id + 8'd1, 1'b1);
      here = next_pc();
      emit(enc_j(op_jal, 11'd4));
      marker(id + 8'd2, 1'b0);
      marker(id + 8'd3, 1'b1);
      store_expect(3'd7, here + 16'd2);
      here = next_pc() + 16'd4;   // JR address after the constant load
      load_const(3'd4, here + 16'd4);
      emit(enc_i2(op_jr, 3'd4, 8'd2));
      marker(id + 8'd4, 1'b0);
      marker(id + 8'd5, 1'b1);
      here = next_pc() + 16'd4;
      load_const(3'd4, here + 16'd4);
      emit(enc_i2(op_jalr, 3'd4, 8'd2));
      marker(id + 8'd6, 1'b0);
      marker(id + 8'd7, 1'b1);
      store_expect(3'd7, here + 16'd2);
      run_program();
   endtask

   task automatic test_halt_err();
      int cycles;
      begin_program();
      emit(enc_i2(op_siic, 3'd0, 8'd0));
      emit(enc_i2(op_rsvd, 3'd0, 8'd0));
      emit(enc_i2(op_nop, 3'd0, 8'd0));
      emit(16'h0000);
      run_program();
      check_word("instr_addr", instr_addr, 16'h0006);
      repeat (4) @(negedge clk);
      check_bit("halted", halted, 1'b1);
      check_word("instr_addr", instr_addr, 16'h0006);
      check_word("store_count", word_t'(st_data.size()), 16'h0000);

      apply_reset();   // Leaves the halted state
      check_word("instr_addr", instr_addr, 16'h0000);
      check_bit("halted", halted, 1'b0);

      begin_program();
      emit(enc_i2(op_nop, 3'd0, 8'd0));
      emit(enc_r(op_btr, 3'd1, 3'd0, 3'd3, 2'd1));   // Funct bits must be clear
      emit(enc_i1(op_st, 3'd0, 3'd0, 5'd0));
      apply_reset();
      cycles = 0;
      while (!err && cycles < 50) begin
         @(negedge clk);
         cycles++;
      end
      if (!err) fail_now("Timeout: the undefined opcode never raised err");
      check_word("instr_addr", instr_addr, 16'h0002);
      repeat (4) @(negedge clk);
      check_bit("err", err, 1'b1);
      check_bit("halted", halted, 1'b0);
      check_word("instr_addr", instr_addr, 16'h0002);
      check_word("store_count", word_t'(st_data.size()), 16'h0000);
   endtask

   initial begin
      tb_rst      = 1'b0;
      seed        = 32'habad_2a99;
      prog_len    = 0;
      for (int i = 0; i < 256; i++) dmem[i] = fill_word(word_t'(i * 2));
      for (int i = 0; i < 128; i++) imem[i] = 16'h0000;
      test_arith();
      test_shift();
      test_memory();
      test_set();
      test_flow();
      test_halt_err();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

/* sim.f */
source/isa_pkg.sv
source/ctrl_pkg.sv
source/control.sv
source/alu.sv
source/reg_file.sv
source/pc_unit.sv
source/cpu_top.sv
test/clk_gen.sv
test/cpu_props.sv
test/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator and run; the result comes from the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f sim.f -o cpu_sim &&
./obj_dir/cpu_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation failed"; exit 1; }
